// ==== all.f ====
apbPkg.sv
execPkg.sv
execAlu.sv
execDecode.sv
execStage.sv
execApbRegs.sv
execTop.sv
execTb.sv

// ==== apbPkg.sv ====
// APB bus structs, register map and status bit layout of the control port.
`default_nettype none
package apbPkg;

   typedef struct packed {
      logic        psel;
      logic        penable;
      logic        pwrite;
      logic [7:0]  paddr;
      logic [31:0] pwdata;
   } apbReqT;

   typedef struct packed {
      logic [31:0] prdata;
      logic        pready;
      logic        pslverr;
   } apbRespT;

   ////////////////////////////////////////////////////////////
   // Register map
   ////////////////////////////////////////////////////////////
   typedef enum logic [7:0] {
      regCtrl   = 8'h00, // Write only, bit 0 is go.
      regPc     = 8'h04,
      regA      = 8'h08,
      regB      = 8'h0C,
      regInstr  = 8'h10,
      regResult = 8'h14, // Read only.
      regNewPc  = 8'h18, // Read only.
      regStatus = 8'h1C  // Read only.
   } regAddrE;

   localparam int statDone    = 0; // Result captured since last CTRL write.
   localparam int statTaken   = 1; // Branch or jump taken.
   localparam int statIllegal = 2; // Unsupported opcode.

endpackage
`default_nettype wire

// ==== execAlu.sv ====
// 16-bit ALU of the execute stage; add, xor, and-not and pass with sum flags.
`timescale 1ns/1ps
`default_nettype none
module execAlu
   import execPkg::*;
(
   input  wire logic [dataW-1:0] inA,
   input  wire logic [dataW-1:0] inB,
   input  wire aluOpE aluOp,
   input  wire logic invA,
   input  wire logic invB,
   input  wire logic cin,
   output logic [dataW-1:0] out,
   output logic zero,
   output logic sign,
   output logic ofl,
   output logic carry
);

   logic [dataW-1:0] opA; // A after optional inversion.
   logic [dataW-1:0] opB; // B after optional inversion.
   logic [dataW-1:0] sum;

   assign opA = invA ? ~inA : inA;
   assign opB = invB ? ~inB : inB;

   // Adder with carry out of the top bit.
   assign {carry, sum} = {1'b0, opA} + {1'b0, opB} + {{dataW{1'b0}}, cin};

   ////////////////////////////////////////////////////////////
   // Result mux
   ////////////////////////////////////////////////////////////
   always_comb begin
      case (aluOp)
         aluAdd:  out = sum;
         aluXor:  out = opA ^ opB;
         aluAndn: out = opA & opB; // B already inverted by invB.
         default: out = opB;       // Pass B.
      endcase
   end

   // Flags always come from the adder.
   assign zero = (sum == '0);
   assign sign = sum[dataW-1];
   assign ofl  = (opA[dataW-1] == opB[dataW-1]) && (sum[dataW-1] != opA[dataW-1]); // Signed.

endmodule
`default_nettype wire

// ==== execApbRegs.sv ====
// APB slave of the execute engine; holds operands and instruction, issues go, serves results.
`timescale 1ns/1ps
`default_nettype none
module execApbRegs
   import apbPkg::*;
   import execPkg::*;
(
   input  wire logic clk,
   input  wire logic reset,
   input  wire apbReqT apbReq,
   output apbRespT apbResp,
   output logic [dataW-1:0] pc,
   output logic [dataW-1:0] a,
   output logic [dataW-1:0] b,
   output logic [dataW-1:0] instr,
   output logic go,
   input  wire execOutT execOut
);

   regAddrE          addr;    // Decoded bus address.
   logic             setup;   // APB setup phase.
   logic             access;  // APB access phase.
   logic             wrOk;    // Address is writable.
   logic             rdOk;    // Address is readable.
   logic [dataW-1:0] rdVal;   // Read mux output.
   logic             doneQ;   // Sticky done flag.
   logic             doneBit; // Done as seen by a read.
   logic [31:0]      rdataQ;
   logic             slverrQ;

   assign addr    = regAddrE'(apbReq.paddr);
   assign setup   = apbReq.psel & ~apbReq.penable;
   assign access  = apbReq.psel & apbReq.penable;
   assign doneBit = doneQ | execOut.done; // Capture edge counts at once.

   ////////////////////////////////////////////////////////////
   // Address decode and read mux
   ////////////////////////////////////////////////////////////
   always_comb begin
      wrOk  = 1'b0;
      rdOk  = 1'b0;
      rdVal = '0;
      case (addr)
         regCtrl: wrOk = 1'b1; // Reads of CTRL are errors.
         regPc: begin
            wrOk  = 1'b1;
            rdOk  = 1'b1;
            rdVal = pc;
         end
         regA: begin
            wrOk  = 1'b1;
            rdOk  = 1'b1;
            rdVal = a;
         end
         regB: begin
            wrOk  = 1'b1;
            rdOk  = 1'b1;
            rdVal = b;
         end
         regInstr: begin
            wrOk  = 1'b1;
            rdOk  = 1'b1;
            rdVal = instr;
         end
         regResult: begin
            rdOk  = 1'b1;
            rdVal = execOut.result;
         end
         regNewPc: begin
            rdOk  = 1'b1;
            rdVal = execOut.newPc;
         end
         regStatus: begin
            rdOk = 1'b1;
            rdVal[statDone]    = doneBit;
            rdVal[statTaken]   = execOut.taken;
            rdVal[statIllegal] = execOut.illegal;
         end
         default: ; // Unmapped, error both ways.
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Registers, go pulse and response
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         pc      <= '0;
         a       <= '0;
         b       <= '0;
         instr   <= '0;
         go      <= 1'b0;
         doneQ   <= 1'b0;
         rdataQ  <= '0;
         slverrQ <= 1'b0;
      end else begin
         go <= 1'b0; // Pulse lasts one cycle.
         if (setup) begin // Response is ready for the access phase.
            rdataQ  <= (!apbReq.pwrite && rdOk) ? {{(32-dataW){1'b0}}, rdVal} : '0;
            slverrQ <= apbReq.pwrite ? ~wrOk : ~rdOk;
         end else begin
            slverrQ <= 1'b0;
         end
         if (access && apbReq.pwrite && wrOk) begin
            case (addr)
               regCtrl:  go    <= apbReq.pwdata[0];
               regPc:    pc    <= apbReq.pwdata[dataW-1:0];
               regA:     a     <= apbReq.pwdata[dataW-1:0];
               regB:     b     <= apbReq.pwdata[dataW-1:0];
               regInstr: instr <= apbReq.pwdata[dataW-1:0];
               default: ;
            endcase
         end
         if (access && apbReq.pwrite && addr == regCtrl) begin
            doneQ <= 1'b0; // New run pending.
         end else if (execOut.done) begin
            doneQ <= 1'b1;
         end
      end
   end

   assign apbResp.prdata  = rdataQ;
   assign apbResp.pready  = 1'b1; // No wait states.
   assign apbResp.pslverr = slverrQ;

   // Access phase always follows a setup phase of the same transfer.
   apbAccessAfterSetup: assert property (@(posedge clk) disable iff (reset)
      apbReq.penable |-> apbReq.psel && $past(apbReq.psel));

endmodule
`default_nettype wire

// ==== execDecode.sv ====
// Instruction decoder; maps an instruction word to execute controls and extended immediates.
`timescale 1ns/1ps
`default_nettype none
module execDecode
   import execPkg::*;
(
   input  wire logic [dataW-1:0] instr,
   output execCtrlT ctrl,
   output execImmT imm
);

   opcodeE opcode;
   logic   imm5Zext; // Logical immediates are zero extended.

   assign opcode = opcodeE'(instr[15:11]);

   ////////////////////////////////////////////////////////////
   // Control table
   ////////////////////////////////////////////////////////////
   always_comb begin
      ctrl              = '0;
      ctrl.aluOp        = aluAdd;
      ctrl.bSrc         = bReg;
      ctrl.resSel       = resAlu;
      ctrl.brKind       = brNone;
      ctrl.writesResult = 1'b1;
      case (opcode)
         opAluR: begin
            case (instr[1:0])
               fnAdd: ;
               fnSub: begin // B minus A.
                  ctrl.invA = 1'b1;
                  ctrl.cin  = 1'b1;
               end
               fnXor: ctrl.aluOp = aluXor;
               default: begin // ANDN, B arrives inverted.
                  ctrl.aluOp = aluAndn;
                  ctrl.invB  = 1'b1;
               end
            endcase
         end
         opAddi: ctrl.bSrc = bImm5;
         opSubi: begin // imm5 minus A.
            ctrl.bSrc = bImm5;
            ctrl.invA = 1'b1;
            ctrl.cin  = 1'b1;
         end
         opXori: begin
            ctrl.bSrc  = bImm5;
            ctrl.aluOp = aluXor;
         end
         opAndni: begin
            ctrl.bSrc  = bImm5;
            ctrl.aluOp = aluAndn;
            ctrl.invB  = 1'b1;
         end
         opSlbi: begin // Low byte is empty after the shift.
            ctrl.bSrc  = bSlbi;
            ctrl.aluOp = aluXor;
         end
         opSeq, opSlt, opSle: begin // Compare through B minus A.
            ctrl.invA   = 1'b1;
            ctrl.cin    = 1'b1;
            ctrl.resSel = (opcode == opSeq) ? resSeq : (opcode == opSlt) ? resSlt : resSle;
         end
         opSco: ctrl.resSel = resCarry;
         opBeqz, opBnez, opBltz, opBgez: begin
            ctrl.writesResult = 1'b0;
            ctrl.brKind = (opcode == opBeqz) ? brEqz :
                          (opcode == opBnez) ? brNez :
                          (opcode == opBltz) ? brLtz : brGez;
         end
         opJ: begin
            ctrl.brKind       = brJump;
            ctrl.writesResult = 1'b0;
         end
         opJr: begin // Target comes out of the ALU.
            ctrl.bSrc         = bImm8;
            ctrl.brKind       = brJumpReg;
            ctrl.writesResult = 1'b0;
         end
         default: begin
            ctrl.aluOp        = aluPassB;
            ctrl.illegal      = 1'b1;
            ctrl.writesResult = 1'b0;
         end
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Immediate extension
   ////////////////////////////////////////////////////////////
   assign imm5Zext  = (opcode == opXori) || (opcode == opAndni);
   assign imm.imm5  = imm5Zext ? {{(dataW-5){1'b0}}, instr[4:0]} :
                                 {{(dataW-5){instr[4]}}, instr[4:0]};
   assign imm.imm8  = {{(dataW-8){instr[7]}}, instr[7:0]};   // Branch offset and JR.
   assign imm.imm11 = {{(dataW-11){instr[10]}}, instr[10:0]}; // J offset.

endmodule
`default_nettype wire

// ==== execPkg.sv ====
// Shared types of the execute engine: opcodes, control fields and the structs between stages.
`default_nettype none
package execPkg;

   localparam int dataW = 16; // Datapath width.

   // Function field, instr[1:0], of the register ALU opcode.
   localparam logic [1:0] fnAdd  = 2'b00;
   localparam logic [1:0] fnSub  = 2'b01;
   localparam logic [1:0] fnXor  = 2'b10;
   localparam logic [1:0] fnAndn = 2'b11;

   ////////////////////////////////////////////////////////////
   // Instruction opcodes, instr[15:11]
   ////////////////////////////////////////////////////////////
   typedef enum logic [4:0] {
      opJ     = 5'b00100, // PC relative jump, imm11.
      opJr    = 5'b00101, // Register jump, A plus imm8.
      opAddi  = 5'b01000,
      opSubi  = 5'b01001, // imm minus A.
      opXori  = 5'b01010,
      opAndni = 5'b01011,
      opBeqz  = 5'b01100,
      opBnez  = 5'b01101,
      opBltz  = 5'b01110,
      opBgez  = 5'b01111,
      opSlbi  = 5'b10010,
      opAluR  = 5'b11011, // ADD, SUB, XOR, ANDN by function field.
      opSeq   = 5'b11100,
      opSlt   = 5'b11101,
      opSle   = 5'b11110,
      opSco   = 5'b11111
   } opcodeE;

   typedef enum logic [1:0] {aluAdd, aluXor, aluAndn, aluPassB} aluOpE;
   typedef enum logic [2:0] {brNone, brEqz, brNez, brLtz, brGez, brJump, brJumpReg} brKindE;
   typedef enum logic [2:0] {resAlu, resSeq, resSlt, resSle, resCarry} resSelE;
   typedef enum logic [1:0] {bReg, bImm5, bImm8, bSlbi} bSrcE;

   typedef struct packed {
      aluOpE  aluOp;
      logic   invA;         // Invert ALU input A.
      logic   invB;         // Invert ALU input B.
      logic   cin;          // ALU carry in.
      bSrcE   bSrc;
      resSelE resSel;
      brKindE brKind;
      logic   illegal;      // Opcode not supported.
      logic   writesResult; // Instruction produces a RESULT value.
   } execCtrlT;

   typedef struct packed {
      logic [dataW-1:0] imm5;  // Zero or sign extended per opcode.
      logic [dataW-1:0] imm8;  // Sign extended.
      logic [dataW-1:0] imm11; // Sign extended.
   } execImmT;

   typedef struct packed {
      logic [dataW-1:0] result;
      logic [dataW-1:0] newPc;
      logic             taken;
      logic             illegal;
      logic             done; // One cycle pulse after capture.
   } execOutT;

endpackage
`default_nettype wire

// ==== execStage.sv ====
// Execute stage; operand muxes, set results, branch decision, next PC and the output register.
`timescale 1ns/1ps
`default_nettype none
module execStage
   import execPkg::*;
(
   input  wire logic clk,
   input  wire logic reset,
   input  wire logic go,
   input  wire logic [dataW-1:0] pc,
   input  wire logic [dataW-1:0] a,
   input  wire logic [dataW-1:0] b,
   input  wire execCtrlT ctrl,
   input  wire execImmT imm,
   output execOutT execOut
);

   logic [dataW-1:0] aluInA;
   logic [dataW-1:0] aluInB;
   logic [dataW-1:0] aluOut;
   logic             zero, sign, ofl, carry; // ALU flags.
   logic             condBr;   // Conditional branch kind.
   logic             diffNeg;  // True sign of B minus A.
   logic [dataW-1:0] resVal;
   logic             taken;
   logic [dataW-1:0] brTarget; // PC relative target.
   logic [dataW-1:0] nextPc;

   assign condBr = ctrl.brKind inside {brEqz, brNez, brLtz, brGez};

   ////////////////////////////////////////////////////////////
   // Operand muxes and ALU
   ////////////////////////////////////////////////////////////
   assign aluInA = (ctrl.bSrc == bSlbi) ? {a[dataW-9:0], 8'h00} : a;

   always_comb begin
      case (ctrl.bSrc)
         bImm5:   aluInB = imm.imm5;
         bImm8:   aluInB = imm.imm8;
         bSlbi:   aluInB = {{(dataW-8){1'b0}}, imm.imm8[7:0]}; // Zero extended.
         default: aluInB = b;
      endcase
      if (condBr) begin
         aluInB = '0; // Flags then describe A alone.
      end
   end

   execAlu alu (
      .inA(aluInA), .inB(aluInB), .aluOp(ctrl.aluOp),
      .invA(ctrl.invA), .invB(ctrl.invB), .cin(ctrl.cin),
      .out(aluOut), .zero(zero), .sign(sign), .ofl(ofl), .carry(carry)
   );

   ////////////////////////////////////////////////////////////
   // Set results
   ////////////////////////////////////////////////////////////
   assign diffNeg = ofl ? ~sign : sign; // Overflow flips the sign.

   always_comb begin
      resVal = '0;
      case (ctrl.resSel)
         resSeq:   resVal[0] = zero;
         resSlt:   resVal[0] = ~diffNeg & ~zero; // B minus A is positive.
         resSle:   resVal[0] = ~diffNeg;
         resCarry: resVal[0] = carry;
         default:  resVal = aluOut;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Branch decision and next PC
   ////////////////////////////////////////////////////////////
   always_comb begin
      case (ctrl.brKind)
         brEqz:             taken = zero;
         brNez:             taken = ~zero;
         brLtz:             taken = sign;
         brGez:             taken = ~sign;
         brJump, brJumpReg: taken = 1'b1;
         default:           taken = 1'b0;
      endcase
   end

   assign brTarget = pc + ((ctrl.brKind == brJump) ? imm.imm11 : imm.imm8);
   assign nextPc   = (ctrl.brKind == brJumpReg) ? aluOut : (taken ? brTarget : pc);

   // Output register, loaded by go.
   always_ff @(posedge clk) begin
      if (reset) begin
         execOut <= '0;
      end else begin
         execOut.done <= go;
         if (go) begin
            execOut.result  <= ctrl.writesResult ? resVal : '0;
            execOut.newPc   <= nextPc;
            execOut.taken   <= taken;
            execOut.illegal <= ctrl.illegal;
         end
      end
   end

   // An illegal opcode never redirects the PC.
   illegalNotTaken: assert property (@(posedge clk) disable iff (reset)
      go && ctrl.illegal |=> !execOut.taken && execOut.newPc == $past(pc));

endmodule
`default_nettype wire

// ==== execTb.sv ====
// Testbench of the execute engine; runs random APB programs and checks them against a model.
`timescale 1ns/1ps
`default_nettype none
module execTb
   import apbPkg::*;
   import execPkg::*;
();

   localparam int maxRuns     = 400; // Instruction runs of all tests rounded up.
   localparam int txPerRun    = 12;  // Five writes, polls and three reads.
   localparam int cyclesPerTx = 3;   // Setup, access and idle cycle.
   localparam int cycleLimit  = maxRuns * txPerRun * cyclesPerTx;
   localparam int maxPolls    = 8;   // STATUS reads before done counts as lost.

   logic             clk;
   logic             reset;
   apbReqT           req;
   apbRespT          resp;
   integer           seed;       // State of $random.
   int               errCount;
   int               checkCount;
   int               cycles = 0;
   logic [dataW-1:0] lastRes;    // Last expected register contents.
   logic [dataW-1:0] lastNewPc;
   logic [2:0]       lastStat;
   logic [dataW-1:0] lastPc;
   logic [dataW-1:0] lastA;
   logic [dataW-1:0] lastB;
   logic [dataW-1:0] lastInstr;

   execTop i_dut (.clk(clk), .reset(reset), .apbReq(req), .apbResp(resp));

   initial clk = 1'b0;
   always #10 clk = ~clk; // 20 ns period.

   // Watchdog on the whole run.
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycleLimit) begin
         $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////////////////////////
   task automatic checkData(input string name, input logic [dataW-1:0] exp,
                            input logic [dataW-1:0] act);
      checkCount++;
      if (act !== exp) begin
         errCount++;
         $display("ERR %s expected %h got %h", name, exp, act);
      end
   endtask

   task automatic checkStatus(input string name, input logic [2:0] exp, input logic [2:0] act);
      checkCount++;
      if (act !== exp) begin
         errCount++;
         $display("ERR %s expected %h got %h", name, exp, act);
      end
   endtask

   task automatic checkResp(input string name, input logic expErr, input apbRespT act);
      checkCount++;
      if (act.pslverr !== expErr) begin
         errCount++;
         $display("ERR %s expected %h got %h", name, expErr, act.pslverr);
      end
      checkCount++;
      if (act.pready !== 1'b1) begin // No wait states on this slave.
         errCount++;
         $display("ERR pready expected %h got %h", 1'b1, act.pready);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // APB transfers, driven on the falling edge
   ////////////////////////////////////////////////////////////
   task automatic apbWrite(input logic [7:0] addr, input logic [dataW-1:0] data,
                           input logic expErr);
      @(negedge clk);
      req.psel    = 1'b1; // Setup phase.
      req.penable = 1'b0;
      req.pwrite  = 1'b1;
      req.paddr   = addr;
      req.pwdata  = {16'h0000, data};
      @(negedge clk);
      req.penable = 1'b1; // Access phase with the response already registered.
      checkResp($sformatf("pslverr write %h", addr), expErr, resp);
      @(negedge clk);
      req.psel    = 1'b0;
      req.penable = 1'b0;
   endtask

   task automatic apbRead(input logic [7:0] addr, input logic expErr,
                          output logic [dataW-1:0] data);
      @(negedge clk);
      req.psel    = 1'b1;
      req.penable = 1'b0;
      req.pwrite  = 1'b0;
      req.paddr   = addr;
      @(negedge clk);
      req.penable = 1'b1;
      checkResp($sformatf("pslverr read %h", addr), expErr, resp);
      checkData("prdata upper half", 16'h0000, resp.prdata[31:16]);
      data = resp.prdata[dataW-1:0];
      @(negedge clk);
      req.psel    = 1'b0;
      req.penable = 1'b0;
   endtask

   ////////////////////////////////////////////////////////////
   // Reference model of one instruction
   ////////////////////////////////////////////////////////////
   task automatic modelExec(input logic [dataW-1:0] instr, input logic [dataW-1:0] pc,
                            input logic [dataW-1:0] a, input logic [dataW-1:0] b,
                            output logic [dataW-1:0] res, output logic [dataW-1:0] newPc,
                            output logic taken, output logic illegal);
      logic [4:0]       op;
      logic [dataW-1:0] s5;   // Immediates as the ISA extends them.
      logic [dataW-1:0] z5;
      logic [dataW-1:0] s8;
      logic [dataW-1:0] s11;
      logic [dataW:0]   wide; // Sum with carry.
      op      = instr[15:11];
      s5      = {{11{instr[4]}}, instr[4:0]};
      z5      = {11'h000, instr[4:0]};
      s8      = {{8{instr[7]}}, instr[7:0]};
      s11     = {{5{instr[10]}}, instr[10:0]};
      res     = '0;
      newPc   = pc;
      taken   = 1'b0;
      illegal = 1'b0;
      case (op)
         opAluR: begin
            case (instr[1:0])
               2'd0:    res = a + b;
               2'd1:    res = b - a;
               2'd2:    res = a ^ b;
               default: res = a & ~b;
            endcase
         end
         opAddi:  res = a + s5;
         opSubi:  res = s5 - a;
         opXori:  res = a ^ z5;
         opAndni: res = a & ~z5;
         opSlbi:  res = {a[7:0], instr[7:0]}; // Shift left 8 and or in the byte.
         opSeq:   res = {15'h0000, (a == b)};
         opSlt:   res = {15'h0000, ($signed(a) < $signed(b))};
         opSle:   res = {15'h0000, ($signed(a) <= $signed(b))};
         opSco: begin
            wide = {1'b0, a} + {1'b0, b};
            res  = {15'h0000, wide[dataW]};
         end
         opBeqz:  taken = (a == 16'h0000);
         opBnez:  taken = (a != 16'h0000);
         opBltz:  taken = a[15];
         opBgez:  taken = ~a[15];
         opJ: begin
            taken = 1'b1;
            newPc = pc + s11;
         end
         opJr: begin
            taken = 1'b1;
            newPc = a + s8;
         end
         default: illegal = 1'b1;
      endcase
      if (taken && op != opJ && op != opJr) begin
         newPc = pc + s8; // Conditional branch target.
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////////////////////////
   function automatic logic [dataW-1:0] randWord();
      logic [31:0] r;
      r = $random(seed);
      return r[15:0];
   endfunction

   function automatic logic [dataW-1:0] edgeValue();
      logic [31:0] r;
      r = $random(seed);
      case (r[2:0])
         3'd0:    return 16'h0000;
         3'd1:    return 16'h0001;
         3'd2:    return 16'h7FFF; // Largest positive.
         3'd3:    return 16'h8000; // Most negative.
         3'd4:    return 16'hFFFF;
         default: return r[31:16];
      endcase
   endfunction

   function automatic logic [4:0] illegalOp();
      logic [31:0] r;
      r = $random(seed);
      case (r[2:0])
         3'd0:    return 5'b00000;
         3'd1:    return 5'b00011;
         3'd2:    return 5'b00110;
         3'd3:    return 5'b00111;
         3'd4:    return 5'b10000;
         3'd5:    return 5'b10001;
         3'd6:    return 5'b10100;
         default: return 5'b11010;
      endcase
   endfunction

   // Loads operands, starts the engine, waits for done and checks all results.
   task automatic runInstr(input logic [dataW-1:0] instr, input logic [dataW-1:0] pc,
                           input logic [dataW-1:0] a, input logic [dataW-1:0] b);
      logic [dataW-1:0] expRes;
      logic [dataW-1:0] expPc;
      logic             expTaken;
      logic             expIll;
      logic [2:0]       expStat;
      logic [dataW-1:0] rd;
      int               polls;
      modelExec(instr, pc, a, b, expRes, expPc, expTaken, expIll);
      apbWrite(regPc, pc, 1'b0);
      apbWrite(regA, a, 1'b0);
      apbWrite(regB, b, 1'b0);
      apbWrite(regInstr, instr, 1'b0);
      apbWrite(regCtrl, 16'h0001, 1'b0); // Go.
      polls = 0;
      rd    = '0;
      while (rd[statDone] == 1'b0 && polls < maxPolls) begin
         apbRead(regStatus, 1'b0, rd);
         polls++;
      end
      if (rd[statDone] == 1'b0) begin
         checkCount++;
         errCount++;
         $display("Done bit never set for instruction %h", instr);
      end
      expStat              = '0;
      expStat[statDone]    = 1'b1;
      expStat[statTaken]   = expTaken;
      expStat[statIllegal] = expIll;
      apbRead(regResult, 1'b0, rd);
      checkData("RESULT", expRes, rd);
      apbRead(regNewPc, 1'b0, rd);
      checkData("NEWPC", expPc, rd);
      apbRead(regStatus, 1'b0, rd);
      checkStatus("STATUS", expStat, rd[2:0]);
      lastRes   = expRes;
      lastNewPc = expPc;
      lastStat  = expStat;
      lastPc    = pc;
      lastA     = a;
      lastB     = b;
      lastInstr = instr;
   endtask

   task automatic reportTest(input string name, input int errStart);
      $display("Test %s finished with %0d errors", name, errCount - errStart);
   endtask

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////
   initial begin
      logic [dataW-1:0] rd;
      logic [dataW-1:0] a;
      logic [dataW-1:0] b;
      logic [dataW-1:0] instr;
      logic [31:0]      r;
      logic [4:0]       op;
      int               k;
      int               errStart;
      seed       = 30;
      errCount   = 0;
      checkCount = 0;
      req        = '0;
      reset      = 1'b1;
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      // Reset values and register read back.
      errStart = errCount;
      apbRead(regResult, 1'b0, rd);
      checkData("RESULT", 16'h0000, rd);
      apbRead(regNewPc, 1'b0, rd);
      checkData("NEWPC", 16'h0000, rd);
      apbRead(regStatus, 1'b0, rd);
      checkData("STATUS", 16'h0000, rd);
      lastPc    = randWord();
      lastA     = randWord();
      lastB     = randWord();
      lastInstr = randWord();
      apbWrite(regPc, lastPc, 1'b0);
      apbWrite(regA, lastA, 1'b0);
      apbWrite(regB, lastB, 1'b0);
      apbWrite(regInstr, lastInstr, 1'b0);
      apbRead(regPc, 1'b0, rd);
      checkData("PC", lastPc, rd);
      apbRead(regA, 1'b0, rd);
      checkData("A", lastA, rd);
      apbRead(regB, 1'b0, rd);
      checkData("B", lastB, rd);
      apbRead(regInstr, 1'b0, rd);
      checkData("INSTR", lastInstr, rd);
      reportTest("reset and read back", errStart);

      // ALU and immediate forms.
      errStart = errCount;
      for (int i = 0; i < 150; i++) begin
         r = $random(seed);
         k = r[31:28] % 9;
         case (k)
            4:       op = opAddi;
            5:       op = opSubi;
            6:       op = opXori;
            7:       op = opAndni;
            8:       op = opSlbi;
            default: op = opAluR;
         endcase
         instr = {op, r[10:0]};
         if (k < 4) begin
            instr[1:0] = k[1:0]; // Function field picks ADD, SUB, XOR or ANDN.
         end
         runInstr(instr, randWord(), randWord(), randWord());
      end
      reportTest("ALU instructions", errStart);

      // Set forms with biased operands.
      errStart = errCount;
      for (int i = 0; i < 100; i++) begin
         r     = $random(seed);
         instr = {3'b111, r[1:0], r[12:2]}; // Set opcodes are 11100 to 11111.
         a     = randWord();
         case (r[14:13])
            2'd0: b = a;
            2'd1: begin
               a = edgeValue();
               b = edgeValue();
            end
            2'd2: begin // Operands of opposite sign.
               a = {r[15], a[14:0]};
               b = {~r[15], r[30:16]};
            end
            default: b = randWord();
         endcase
         runInstr(instr, randWord(), a, b);
      end
      reportTest("set instructions", errStart);

      // Branches and jumps over zero, negative and positive A.
      errStart = errCount;
      for (int i = 0; i < 100; i++) begin
         r = $random(seed);
         k = r[31:29] % 6;
         case (k)
            0:       op = opBeqz;
            1:       op = opBnez;
            2:       op = opBltz;
            3:       op = opBgez;
            4:       op = opJ;
            default: op = opJr;
         endcase
         instr = {op, r[10:0]};
         case (r[12:11])
            2'd0:    a = 16'h0000;
            2'd1:    a = {1'b1, r[27:13]};
            2'd2:    a = {1'b0, r[27:13]};
            default: a = edgeValue();
         endcase
         runInstr(instr, randWord(), a, randWord());
      end
      reportTest("branches and jumps", errStart);

      // Unsupported opcodes.
      errStart = errCount;
      for (int i = 0; i < 20; i++) begin
         r     = $random(seed);
         instr = {illegalOp(), r[10:0]};
         runInstr(instr, randWord(), randWord(), randWord());
      end
      reportTest("illegal opcodes", errStart);

      // Bad accesses are refused and change nothing.
      errStart = errCount;
      apbWrite(regResult, randWord(), 1'b1);
      apbWrite(regNewPc, randWord(), 1'b1);
      apbWrite(regStatus, randWord(), 1'b1);
      apbWrite(8'h20, randWord(), 1'b1);
      apbWrite(8'h06, randWord(), 1'b1);
      apbRead(regCtrl, 1'b1, rd);
      checkData("CTRL read data", 16'h0000, rd);
      apbRead(8'h30, 1'b1, rd);
      apbRead(regResult, 1'b0, rd);
      checkData("RESULT", lastRes, rd);
      apbRead(regNewPc, 1'b0, rd);
      checkData("NEWPC", lastNewPc, rd);
      apbRead(regStatus, 1'b0, rd);
      checkStatus("STATUS", lastStat, rd[2:0]);
      apbRead(regPc, 1'b0, rd);
      checkData("PC", lastPc, rd);
      apbRead(regA, 1'b0, rd);
      checkData("A", lastA, rd);
      apbRead(regB, 1'b0, rd);
      checkData("B", lastB, rd);
      apbRead(regInstr, 1'b0, rd);
      checkData("INSTR", lastInstr, rd);
      reportTest("illegal accesses", errStart);

      $display("Checks: %0d passed, %0d failed", checkCount - errCount, errCount);
      if (errCount == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule
`default_nettype wire

// ==== execTop.sv ====
// Top level of the execute engine; connects the APB slave, decoder and execute stage.
`timescale 1ns/1ps
`default_nettype none
module execTop
   import apbPkg::*;
   import execPkg::*;
(
   input  wire logic clk,
   input  wire logic reset,
   input  wire apbReqT apbReq,
   output apbRespT apbResp
);

   logic [dataW-1:0] pc;
   logic [dataW-1:0] a;
   logic [dataW-1:0] b;
   logic [dataW-1:0] instr;
   logic             go;      // Start pulse to the stage.
   execCtrlT         ctrl;
   execImmT          imm;
   execOutT          execOut; // Captured results.

   execApbRegs regs (
      .clk(clk), .reset(reset), .apbReq(apbReq), .apbResp(apbResp),
      .pc(pc), .a(a), .b(b), .instr(instr), .go(go), .execOut(execOut)
   );

   execDecode decode (
      .instr(instr), .ctrl(ctrl), .imm(imm)
   );

   execStage stage (
      .clk(clk), .reset(reset), .go(go), .pc(pc), .a(a), .b(b),
      .ctrl(ctrl), .imm(imm), .execOut(execOut)
   );

endmodule
`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module execTb -o execSim
./obj_dir/execSim | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
   exit 1
fi
exit 0
